//--- rtl/rename_pkg.sv
package rename_pkg;

    // group shape
    localparam int group_width  = 4;

    // architectural side
    localparam int arch_reg_num = 32;
    localparam int arch_idx_w   = 5;

    // physical side
    localparam int preg_num     = 64;
    localparam int preg_idx_w   = 6;

    // pregs left unmapped after reset, they seed the free list
    localparam int free_depth   = 32;
    localparam int free_cnt_w   = 6;  // holds 0..free_depth

    typedef logic [arch_idx_w-1:0] arch_idx_t;
    typedef logic [preg_idx_w-1:0] preg_idx_t;

    // per-group count 0..group_width
    typedef logic [2:0] slot_cnt_t;

endpackage

//--- rtl/rename_map_table.sv
`timescale 1ns/1ps

module rename_map_table import rename_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    // lookup, straight from the decoded slots
    input  arch_idx_t rj [group_width],
    input  arch_idx_t rk [group_width],
    input  arch_idx_t rd [group_width],

    // mapping updates from the accepted group
    input  logic      map_we [group_width],
    input  arch_idx_t map_wr_arch [group_width],
    input  preg_idx_t map_wr_preg [group_width],

    output preg_idx_t map_rj [group_width],
    output preg_idx_t map_rk [group_width],
    output preg_idx_t map_rd_old [group_width]
);

    preg_idx_t map_q [arch_reg_num];  // arch -> preg

    // asynchronous reads, 3 per slot
    always_comb begin
        for (int i = 0; i < group_width; i++) begin
            map_rj[i]     = map_q[rj[i]];
            map_rk[i]     = map_q[rk[i]];
            map_rd_old[i] = map_q[rd[i]];  // mapping before this group
        end
    end

    // slots are walked in order so the last writer of an arch reg sticks
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int a = 0; a < arch_reg_num; a++) begin
                map_q[a] <= preg_idx_t'(a);  // identity mapping
            end
        end else begin
            for (int i = 0; i < group_width; i++) begin
                // r0 stays pinned to p0
                if (map_we[i] && (map_wr_arch[i] != '0)) begin
                    map_q[map_wr_arch[i]] <= map_wr_preg[i];
                end
            end
        end
    end

endmodule

//--- rtl/rename_free_list.sv
`timescale 1ns/1ps

module rename_free_list import rename_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      fire,

    // destination fields of the incoming group
    input  logic      slot_valid [group_width],
    input  logic      rd_exist [group_width],
    input  arch_idx_t rd [group_width],

    // pregs released at retire
    input  logic      free_valid [group_width],
    input  preg_idx_t free_preg [group_width],

    output preg_idx_t head_preg [group_width],
    output logic      enough
);

    typedef logic [$clog2(free_depth)-1:0] ptr_t;

    preg_idx_t             fifo_q [free_depth];
    ptr_t                  head_q;
    ptr_t                  tail_q;
    logic [free_cnt_w-1:0] count_q;

    logic      alloc [group_width];
    slot_cnt_t alloc_pos [group_width];  // rank among allocating slots
    slot_cnt_t push_pos [group_width];   // rank among released pregs
    slot_cnt_t alloc_cnt;
    slot_cnt_t push_cnt;
    slot_cnt_t pop_cnt;

    // prefix counts for both sides
    always_comb begin
        alloc_cnt = '0;
        push_cnt  = '0;
        for (int i = 0; i < group_width; i++) begin
            alloc[i]     = slot_valid[i] && rd_exist[i] && (rd[i] != '0);
            alloc_pos[i] = alloc_cnt;
            push_pos[i]  = push_cnt;
            alloc_cnt    = alloc_cnt + slot_cnt_t'(alloc[i]);
            push_cnt     = push_cnt + slot_cnt_t'(free_valid[i]);
        end
    end

    // each allocating slot peeks at its own entry past the head
    always_comb begin
        for (int i = 0; i < group_width; i++) begin
            head_preg[i] = alloc[i] ? fifo_q[head_q + ptr_t'(alloc_pos[i])] : '0;
        end
    end

    assign enough  = count_q >= free_cnt_w'(alloc_cnt);
    assign pop_cnt = fire ? alloc_cnt : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // p32..p63 queued in order, list starts full
            for (int i = 0; i < free_depth; i++) begin
                fifo_q[i] <= preg_idx_t'(preg_num - free_depth + i);
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= free_cnt_w'(free_depth);
        end else begin
            for (int i = 0; i < group_width; i++) begin
                if (free_valid[i]) begin
                    fifo_q[tail_q + ptr_t'(push_pos[i])] <= free_preg[i];
                end
            end
            tail_q  <= tail_q + ptr_t'(push_cnt);
            head_q  <= head_q + ptr_t'(pop_cnt);
            // releases and allocations may land on the same edge
            count_q <= count_q + free_cnt_w'(push_cnt) - free_cnt_w'(pop_cnt);
        end
    end

endmodule

//--- rtl/rename_resolve.sv
`timescale 1ns/1ps

module rename_resolve import rename_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    input  logic      decoder_valid,
    input  logic      issue_ready,
    input  logic      enough,

    input  logic      slot_valid [group_width],
    input  logic      rd_exist [group_width],
    input  logic      rj_exist [group_width],
    input  logic      rk_exist [group_width],
    input  arch_idx_t rd [group_width],
    input  arch_idx_t rj [group_width],
    input  arch_idx_t rk [group_width],

    input  preg_idx_t head_preg [group_width],
    input  preg_idx_t map_rj [group_width],
    input  preg_idx_t map_rk [group_width],
    input  preg_idx_t map_rd_old [group_width],

    output logic      rename_ready,
    output logic      fire,
    output logic      map_we [group_width],
    output arch_idx_t map_wr_arch [group_width],
    output preg_idx_t map_wr_preg [group_width],

    output logic      rename_valid,
    output logic      out_slot_valid [group_width],
    output preg_idx_t out_preg_rd [group_width],
    output preg_idx_t out_preg_rj [group_width],
    output preg_idx_t out_preg_rk [group_width],
    output preg_idx_t out_history_preg [group_width]
);

    logic      alloc [group_width];
    preg_idx_t new_rj [group_width];
    preg_idx_t new_rk [group_width];
    preg_idx_t new_hist [group_width];

    // free list hands out 0 to slots that do not allocate
    always_comb begin
        for (int i = 0; i < group_width; i++) begin
            alloc[i] = slot_valid[i] && rd_exist[i] && (head_preg[i] != '0);
        end
    end

    // in-group RAW and WAW forwarding
    // earlier slots scanned in order, so the latest matching writer wins
    always_comb begin
        for (int i = 0; i < group_width; i++) begin
            new_rj[i]   = map_rj[i];
            new_rk[i]   = map_rk[i];
            new_hist[i] = map_rd_old[i];
            for (int j = 0; j < i; j++) begin
                if (alloc[j] && (rd[j] == rj[i])) new_rj[i] = head_preg[j];
                if (alloc[j] && (rd[j] == rk[i])) new_rk[i] = head_preg[j];
                if (alloc[j] && (rd[j] == rd[i])) new_hist[i] = head_preg[j];
            end
            if (!rj_exist[i]) new_rj[i] = '0;
            if (!rk_exist[i]) new_rk[i] = '0;
            if (!alloc[i]) new_hist[i] = '0;  // no rd, no history
        end
    end

    assign rename_ready = enough && issue_ready;
    assign fire         = decoder_valid && rename_ready;

    // map updates, applied on the accepting edge
    always_comb begin
        for (int i = 0; i < group_width; i++) begin
            map_we[i]      = fire && alloc[i];
            map_wr_arch[i] = rd[i];
            map_wr_preg[i] = head_preg[i];
        end
    end

    // group register toward dispatch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rename_valid <= 1'b0;
            for (int i = 0; i < group_width; i++) begin
                out_slot_valid[i]   <= 1'b0;
                out_preg_rd[i]      <= '0;
                out_preg_rj[i]      <= '0;
                out_preg_rk[i]      <= '0;
                out_history_preg[i] <= '0;
            end
        end else if (issue_ready) begin  // dispatch stalled -> hold everything
            rename_valid <= fire;
            if (fire) begin
                for (int i = 0; i < group_width; i++) begin
                    out_slot_valid[i]   <= slot_valid[i];
                    out_preg_rd[i]      <= head_preg[i];
                    out_preg_rj[i]      <= new_rj[i];
                    out_preg_rk[i]      <= new_rk[i];
                    out_history_preg[i] <= new_hist[i];
                end
            end
        end
    end

endmodule

//--- rtl/rename_top.sv
`timescale 1ns/1ps

module rename_top import rename_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    // decoded group
    input  logic      decoder_valid,
    input  logic      slot_valid [group_width],
    input  logic      rd_exist [group_width],
    input  arch_idx_t rd [group_width],
    input  logic      rj_exist [group_width],
    input  arch_idx_t rj [group_width],
    input  logic      rk_exist [group_width],
    input  arch_idx_t rk [group_width],

    input  logic      issue_ready,

    // retire side releases
    input  logic      free_valid [group_width],
    input  preg_idx_t free_preg [group_width],

    output logic      rename_ready,
    output logic      rename_valid,
    output logic      out_slot_valid [group_width],
    output preg_idx_t out_preg_rd [group_width],
    output preg_idx_t out_preg_rj [group_width],
    output preg_idx_t out_preg_rk [group_width],
    output preg_idx_t out_history_preg [group_width]
);

    preg_idx_t map_rj [group_width];
    preg_idx_t map_rk [group_width];
    preg_idx_t map_rd_old [group_width];
    preg_idx_t head_preg [group_width];
    logic      enough;
    logic      fire;
    logic      map_we [group_width];
    arch_idx_t map_wr_arch [group_width];
    preg_idx_t map_wr_preg [group_width];

    rename_map_table map_table_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .rj          (rj),
        .rk          (rk),
        .rd          (rd),
        .map_we      (map_we),
        .map_wr_arch (map_wr_arch),
        .map_wr_preg (map_wr_preg),
        .map_rj      (map_rj),
        .map_rk      (map_rk),
        .map_rd_old  (map_rd_old)
    );

    rename_free_list free_list_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .fire       (fire),
        .slot_valid (slot_valid),
        .rd_exist   (rd_exist),
        .rd         (rd),
        .free_valid (free_valid),
        .free_preg  (free_preg),
        .head_preg  (head_preg),
        .enough     (enough)
    );

    rename_resolve resolve_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .decoder_valid    (decoder_valid),
        .issue_ready      (issue_ready),
        .enough           (enough),
        .slot_valid       (slot_valid),
        .rd_exist         (rd_exist),
        .rj_exist         (rj_exist),
        .rk_exist         (rk_exist),
        .rd               (rd),
        .rj               (rj),
        .rk               (rk),
        .head_preg        (head_preg),
        .map_rj           (map_rj),
        .map_rk           (map_rk),
        .map_rd_old       (map_rd_old),
        .rename_ready     (rename_ready),
        .fire             (fire),
        .map_we           (map_we),
        .map_wr_arch      (map_wr_arch),
        .map_wr_preg      (map_wr_preg),
        .rename_valid     (rename_valid),
        .out_slot_valid   (out_slot_valid),
        .out_preg_rd      (out_preg_rd),
        .out_preg_rj      (out_preg_rj),
        .out_preg_rk      (out_preg_rk),
        .out_history_preg (out_history_preg)
    );

endmodule

//--- verif/rename_assertions.sv
`timescale 1ns/1ps

module rename_assertions import rename_pkg::*; (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  issue_ready,
    input logic                  rename_valid,
    input logic                  fire,
    input logic                  slot_valid [group_width],
    input logic                  rd_exist [group_width],
    input arch_idx_t             rd [group_width],
    input logic [free_cnt_w-1:0] free_count,
    input logic                  out_slot_valid [group_width],
    input preg_idx_t             out_preg_rd [group_width],
    input preg_idx_t             out_preg_rj [group_width],
    input preg_idx_t             out_preg_rk [group_width],
    input preg_idx_t             out_history_preg [group_width]
);

    logic [group_width-1:0][4*preg_idx_w:0] out_flat;  // whole output group
    slot_cnt_t                              need;      // slots asking for a new preg

    always_comb begin
        for (int i = 0; i < group_width; i++) begin
            out_flat[i] = {out_slot_valid[i], out_preg_rd[i], out_preg_rj[i],
                           out_preg_rk[i], out_history_preg[i]};
        end
    end

    always_comb begin
        need = '0;
        for (int i = 0; i < group_width; i++) begin
            if (slot_valid[i] && rd_exist[i] && (rd[i] != '0)) begin
                need = need + 1'b1;
            end
        end
    end

    valid_low_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !rename_valid)
        else $error("rename_valid high on the first edge after reset");

    // group must sit still while dispatch is stalled
    hold_while_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        rename_valid && !issue_ready |=> $stable(out_flat) && rename_valid)
        else $error("renamed group changed while dispatch was stalled");

    count_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        free_count <= free_cnt_w'(free_depth))
        else $error("free list count above its depth");

    fire_needs_enough: assert property (@(posedge clk) disable iff (!rst_n)
        fire |-> free_count >= free_cnt_w'(need))
        else $error("group accepted without enough free registers");

endmodule

bind rename_top rename_assertions assertions_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .issue_ready      (issue_ready),
    .rename_valid     (rename_valid),
    .fire             (fire),
    .slot_valid       (slot_valid),
    .rd_exist         (rd_exist),
    .rd               (rd),
    .free_count       (free_list_i.count_q),
    .out_slot_valid   (out_slot_valid),
    .out_preg_rd      (out_preg_rd),
    .out_preg_rj      (out_preg_rj),
    .out_preg_rk      (out_preg_rk),
    .out_history_preg (out_history_preg)
);

//--- verif/rename_tb.sv
`timescale 1ns/1ps

module rename_tb import rename_pkg::*; ();

    localparam int timeout_cycles = 4000;  // run needs about 360

    logic      clk;
    logic      rst_n;
    logic      decoder_valid;
    logic      issue_ready;
    logic      slot_valid [group_width];
    logic      rd_exist [group_width];
    arch_idx_t rd [group_width];
    logic      rj_exist [group_width];
    arch_idx_t rj [group_width];
    logic      rk_exist [group_width];
    arch_idx_t rk [group_width];
    logic      free_valid [group_width];
    preg_idx_t free_preg [group_width];
    logic      rename_ready;
    logic      rename_valid;
    logic      out_slot_valid [group_width];
    preg_idx_t out_preg_rd [group_width];
    preg_idx_t out_preg_rj [group_width];
    preg_idx_t out_preg_rk [group_width];
    preg_idx_t out_history_preg [group_width];

    // reference model state
    preg_idx_t ref_map [arch_reg_num];
    preg_idx_t free_q [$];
    preg_idx_t retire_q [$];  // superseded mappings waiting for release
    logic      exp_valid = 1'b0;
    logic      exp_sv [group_width];
    preg_idx_t exp_rd [group_width];
    preg_idx_t exp_rj [group_width];
    preg_idx_t exp_rk [group_width];
    preg_idx_t exp_hist [group_width];

    int          err_preg = 0;
    int          err_level = 0;
    int          cycle_cnt = 0;
    logic [31:0] lfsr_state = 32'h54c6_0e9e;

    rename_top rename_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = (lfsr_state >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
        return b;
    endfunction

    function automatic logic [31:0] lfsr_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_bit()};
        end
        return r;
    endfunction

    task automatic check_preg(string name, preg_idx_t got, preg_idx_t exp);
        if (got !== exp) begin
            err_preg++;
            $display("error %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_level(string name, logic got, logic exp);
        if (got !== exp) begin
            err_level++;
            $display("error %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic clear_inputs();
        decoder_valid <= 1'b0;
        issue_ready   <= 1'b1;
        for (int i = 0; i < group_width; i++) begin
            slot_valid[i] <= 1'b0;
            rd_exist[i]   <= 1'b0;
            rd[i]         <= '0;
            rj_exist[i]   <= 1'b0;
            rj[i]         <= '0;
            rk_exist[i]   <= 1'b0;
            rk[i]         <= '0;
            free_valid[i] <= 1'b0;
            free_preg[i]  <= '0;
        end
    endtask

    // valid slot with all three fields present
    task automatic set_slot(int i, arch_idx_t d, arch_idx_t j, arch_idx_t k);
        slot_valid[i] <= 1'b1;
        rd_exist[i]   <= 1'b1;
        rd[i]         <= d;
        rj_exist[i]   <= 1'b1;
        rj[i]         <= j;
        rk_exist[i]   <= 1'b1;
        rk[i]         <= k;
    endtask

    task automatic release_retired(int n);
        for (int i = 0; i < n; i++) begin
            if (retire_q.size() > 0) begin
                free_valid[i] <= 1'b1;
                free_preg[i]  <= retire_q.pop_front();
            end
        end
    endtask

    task automatic compare_outputs();
        check_level("rename_valid", rename_valid, exp_valid);
        for (int i = 0; i < group_width; i++) begin
            check_level($sformatf("out_slot_valid[%0d]", i), out_slot_valid[i], exp_sv[i]);
            check_preg($sformatf("out_preg_rd[%0d]", i), out_preg_rd[i], exp_rd[i]);
            check_preg($sformatf("out_preg_rj[%0d]", i), out_preg_rj[i], exp_rj[i]);
            check_preg($sformatf("out_preg_rk[%0d]", i), out_preg_rk[i], exp_rk[i]);
            check_preg($sformatf("out_history_preg[%0d]", i), out_history_preg[i],
                       exp_hist[i]);
        end
    endtask

    // applies the rename rules slot by slot to the inputs of this cycle
    task automatic predict_group();
        logic alloc [group_width];
        logic exp_ready;
        int   need;
        need = 0;
        for (int i = 0; i < group_width; i++) begin
            alloc[i] = slot_valid[i] && rd_exist[i] && (rd[i] != '0);
            if (alloc[i]) need++;
        end
        exp_ready = issue_ready && (free_q.size() >= need);
        check_level("rename_ready", rename_ready, exp_ready);
        if (issue_ready) exp_valid = decoder_valid && exp_ready;
        if (decoder_valid && exp_ready) begin
            for (int i = 0; i < group_width; i++) begin
                exp_sv[i]   = slot_valid[i];
                exp_rj[i]   = rj_exist[i] ? ref_map[rj[i]] : '0;
                exp_rk[i]   = rk_exist[i] ? ref_map[rk[i]] : '0;
                exp_rd[i]   = '0;
                exp_hist[i] = '0;
                if (alloc[i]) begin
                    exp_hist[i]    = ref_map[rd[i]];
                    exp_rd[i]      = free_q.pop_front();
                    ref_map[rd[i]] = exp_rd[i];  // later slots see this one
                    retire_q.push_back(exp_hist[i]);
                end
            end
        end
        for (int i = 0; i < group_width; i++) begin
            if (free_valid[i]) free_q.push_back(free_preg[i]);
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        compare_outputs();
        predict_group();
        @(posedge clk);
    endtask

    task automatic independent_writers();
        clear_inputs();
        decoder_valid <= 1'b1;
        for (int i = 0; i < group_width; i++) begin
            set_slot(i, arch_idx_t'(i + 1), arch_idx_t'(i + 5), arch_idx_t'(i + 9));
        end
        next_cycle();
        clear_inputs();
        next_cycle();
    endtask

    task automatic in_group_forwarding();
        clear_inputs();
        decoder_valid <= 1'b1;
        set_slot(0, 5, 1, 2);
        set_slot(1, 6, 5, 3);  // RAW on slot 0
        set_slot(2, 5, 4, 6);  // WAW with slot 0
        set_slot(3, 7, 1, 5);  // r5 from slot 2
        next_cycle();
        clear_inputs();
        decoder_valid <= 1'b1;
        set_slot(0, 8, 5, 6);
        next_cycle();
        clear_inputs();
        next_cycle();
    endtask

    task automatic missing_destinations();
        clear_inputs();
        decoder_valid <= 1'b1;
        set_slot(0, 0, 1, 2);
        set_slot(1, 9, 3, 4);
        rd_exist[1] <= 1'b0;
        set_slot(2, 10, 5, 6);
        rj_exist[2] <= 1'b0;
        set_slot(3, 11, 7, 8);
        slot_valid[3] <= 1'b0;
        next_cycle();
        clear_inputs();
        decoder_valid <= 1'b1;
        for (int i = 0; i < group_width; i++) begin
            set_slot(i, arch_idx_t'(i + 12), arch_idx_t'(i + 10), 0);
        end
        next_cycle();
        clear_inputs();
        next_cycle();
    endtask

    task automatic free_list_exhaustion();
        clear_inputs();
        decoder_valid <= 1'b1;
        for (int i = 0; i < group_width; i++) begin
            set_slot(i, arch_idx_t'(i + 16), arch_idx_t'(i + 1), arch_idx_t'(i + 2));
        end
        while (free_q.size() >= group_width) next_cycle();
        repeat (2) next_cycle();  // group waits on a short list
        release_retired(group_width);
        next_cycle();
        for (int i = 0; i < group_width; i++) begin
            free_valid[i] <= 1'b0;
        end
        next_cycle();
        clear_inputs();
        next_cycle();
    endtask

    task automatic dispatch_stall();
        clear_inputs();
        release_retired(group_width);
        next_cycle();
        clear_inputs();
        decoder_valid <= 1'b1;
        set_slot(0, 20, 16, 17);
        set_slot(1, 21, 20, 1);
        next_cycle();
        set_slot(0, 22, 21, 20);
        set_slot(1, 23, 22, 2);
        issue_ready <= 1'b0;
        repeat (5) next_cycle();
        issue_ready <= 1'b1;
        next_cycle();
        clear_inputs();
        next_cycle();
    endtask

    task automatic random_groups(int n);
        for (int c = 0; c < n; c++) begin
            clear_inputs();
            decoder_valid <= lfsr_bit() | lfsr_bit();
            issue_ready   <= lfsr_bit() | lfsr_bit() | lfsr_bit();
            for (int i = 0; i < group_width; i++) begin
                slot_valid[i] <= lfsr_bit() | lfsr_bit();
                rd_exist[i]   <= lfsr_bit() | lfsr_bit();
                rd[i]         <= arch_idx_t'(lfsr_bits(arch_idx_w));
                rj_exist[i]   <= lfsr_bit();
                rj[i]         <= arch_idx_t'(lfsr_bits(arch_idx_w));
                rk_exist[i]   <= lfsr_bit();
                rk[i]         <= arch_idx_t'(lfsr_bits(arch_idx_w));
                if (retire_q.size() > 0 && lfsr_bit()) begin
                    free_valid[i] <= 1'b1;
                    free_preg[i]  <= retire_q.pop_front();
                end
            end
            next_cycle();
        end
        clear_inputs();
        next_cycle();
    endtask

    initial begin
        clear_inputs();
        rst_n <= 1'b0;
        for (int i = 0; i < group_width; i++) begin
            exp_sv[i]   = 1'b0;
            exp_rd[i]   = '0;
            exp_rj[i]   = '0;
            exp_rk[i]   = '0;
            exp_hist[i] = '0;
        end
        for (int a = 0; a < arch_reg_num; a++) begin
            ref_map[a] = preg_idx_t'(a);
        end
        for (int i = 0; i < free_depth; i++) begin
            free_q.push_back(preg_idx_t'(preg_num - free_depth + i));
        end
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        independent_writers();
        in_group_forwarding();
        missing_destinations();
        free_list_exhaustion();
        dispatch_stall();
        random_groups(300);
        $display("summary: %0d preg errors, %0d level errors", err_preg, err_level);
        if (err_preg + err_level == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- list.f
rtl/rename_pkg.sv
rtl/rename_map_table.sv
rtl/rename_free_list.sv
rtl/rename_resolve.sv
rtl/rename_top.sv
verif/rename_assertions.sv
verif/rename_tb.sv

//--- run.sh
#!/bin/sh
# build and run the rename stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module rename_tb \
    -Mdir obj_dir \
    -f list.f

status=0
./obj_dir/Vrename_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Test failures found" sim.log; then
    echo "simulation failed"
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "All tests passed!" sim.log; then
    echo "simulation ended without a clean finish"
    exit 1
fi
echo "simulation passed"
